// ==== flist.f ====
+incdir+.
lsu_pkg.sv
lsu_req_dispatch.sv
mem_bank.sv
lsu_result_collect.sv
lsu_mem_top.sv
tb_lsu_mem.sv

// ==== Bender.yml ====
package:
  name: lsu_mem

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - lsu_pkg.sv
      - lsu_req_dispatch.sv
      - mem_bank.sv
      - lsu_result_collect.sv
      - lsu_mem_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_lsu_mem.sv

// ==== tb_lsu_mem.sv ====
`include "lsu_defines.svh"

module tb_lsu_mem;

    localparam int IDX_W     = `LSU_ADDR_W - 2;
    localparam int NUM_WORDS = `LSU_NUM_BANKS * `LSU_BANK_WORDS;
    localparam int EXP_W     = `LSU_TAG_W + `LSU_PHY_W + 1 + `LSU_ADDR_W + 32;

    logic                   clk;
    logic                   reset;
    logic                   req;
    logic                   req_store;
    lsu_pkg::funct3_e       req_funct3;
    logic [`LSU_ADDR_W-1:0] req_addr;
    logic [31:0]            req_wdata;
    logic [`LSU_TAG_W-1:0]  req_tag;
    logic [`LSU_PHY_W-1:0]  req_phy;
    logic                   ack;
    logic                   commit_valid;
    logic [`LSU_ADDR_W-1:0] commit_addr;
    logic [31:0]            commit_data;
    lsu_pkg::funct3_e       commit_funct3;
    logic                   flush;
    logic                   result_valid;
    logic [`LSU_TAG_W-1:0]  result_tag;
    logic [`LSU_PHY_W-1:0]  result_phy;
    logic [31:0]            result_data;
    logic                   result_store;
    logic [`LSU_ADDR_W-1:0] result_addr;

    logic [31:0]            spec_m [NUM_WORDS];  // Model of the speculative image
    logic [31:0]            cmt_m  [NUM_WORDS];  // Model of the committed image
    logic [EXP_W-1:0]       exp_q [$];           // Tag, phy, store, addr, data
    logic [EXP_W-1:0]       exp_r;
    logic [`LSU_ADDR_W-1:0] base;
    logic [`LSU_TAG_W-1:0]  tag_ctr = '0;
    string                  test_name = "reset";
    integer                 seed = 96;
    int                     ops_issued = 0;
    int                     cycles = 0;
    int                     errors = 0;

    lsu_mem_top dut0 (
        .clk(clk), .reset(reset),
        .req(req), .req_store(req_store), .req_funct3(req_funct3), .req_addr(req_addr),
        .req_wdata(req_wdata), .req_tag(req_tag), .req_phy(req_phy), .ack(ack),
        .commit_valid(commit_valid), .commit_addr(commit_addr),
        .commit_data(commit_data), .commit_funct3(commit_funct3), .flush(flush),
        .result_valid(result_valid), .result_tag(result_tag), .result_phy(result_phy),
        .result_data(result_data), .result_store(result_store), .result_addr(result_addr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "run stopped on first failure");
    endtask

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            errors = errors + 1;
            abort_run($sformatf("error: %s %s expected %h actual %h",
                                test_name, what, expected, actual));
        end
    endtask

    // Expected load value from width code, byte offset and stored word
    function automatic logic [31:0] ref_load(input logic [2:0] f3, input logic [1:0] off,
                                             input logic [31:0] word);
        logic [7:0]  bv;
        logic [15:0] hv;
        bv = 8'(word >> (8 * off));
        hv = 16'(word >> (16 * off[1]));
        case (f3)
            3'b000:  ref_load = {{24{bv[7]}}, bv};
            3'b001:  ref_load = {{16{hv[15]}}, hv};
            3'b010:  ref_load = word;
            3'b100:  ref_load = {24'd0, bv};
            3'b101:  ref_load = {16'd0, hv};
            default: ref_load = 32'd0;
        endcase
    endfunction

    // Store or commit merged into the old word by lane mask
    function automatic logic [31:0] ref_merge(input logic [31:0] old, input logic [31:0] data,
                                              input logic [2:0] f3, input logic [1:0] off);
        logic [31:0] mask;
        int          shift;
        case (f3)
            3'b000:  shift = 8 * off;
            3'b001:  shift = 16 * off[1];
            default: shift = 0;
        endcase
        case (f3)
            3'b000:  mask = 32'h0000_00ff << shift;
            3'b001:  mask = 32'h0000_ffff << shift;
            3'b010:  mask = 32'hffff_ffff;
            default: mask = 32'd0;  // Illegal width leaves the word alone
        endcase
        ref_merge = (old & ~mask) | ((data << shift) & mask);
    endfunction

    function automatic logic [`LSU_ADDR_W-1:0] align_addr(input logic [2:0] f3,
                                                         input logic [`LSU_ADDR_W-1:0] a);
        case (f3[1:0])
            2'b01:   align_addr = {a[`LSU_ADDR_W-1:1], 1'b0};
            2'b10:   align_addr = {a[`LSU_ADDR_W-1:2], 2'b00};
            default: align_addr = a;
        endcase
    endfunction

    task automatic restore_model();
        for (int i = 0; i < NUM_WORDS; i++) begin
            spec_m[i] = cmt_m[i];
        end
    endtask

    // Four-phase access, cancel_at picks the flush point or -1 for none
    task automatic do_access(input logic store, input logic [2:0] f3,
                             input logic [`LSU_ADDR_W-1:0] addr, input logic [31:0] wdata,
                             input int cancel_at);
        logic [IDX_W-1:0]      idx;
        logic [`LSU_PHY_W-1:0] phy;
        int                    waited;
        idx        = addr[`LSU_ADDR_W-1:2];
        phy        = `LSU_PHY_W'($random(seed));
        tag_ctr    = tag_ctr + 1'b1;
        ops_issued = ops_issued + 1;
        @(posedge clk);
        #1;
        check("ack idle before req", 0, ack);
        req        = 1'b1;
        req_store  = store;
        req_funct3 = lsu_pkg::funct3_e'(f3);
        req_addr   = addr;
        req_wdata  = wdata;
        req_tag    = tag_ctr;
        req_phy    = phy;
        if (cancel_at == 0) flush = 1'b1;  // Same edge as acceptance
        if (cancel_at < 0) begin
            exp_q.push_back({tag_ctr, phy, store, addr[`LSU_ADDR_W-1:2], 2'b00,
                             store ? 32'd0 : ref_load(f3, addr[1:0], spec_m[idx])});
            if (store) spec_m[idx] = ref_merge(spec_m[idx], wdata, f3, addr[1:0]);
        end else begin
            restore_model();
        end
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            flush  = 1'b0;
            waited = waited + 1;
        end while (!ack);
        check("ack rise cycles", 1, waited);
        req = 1'b0;
        if (cancel_at == 1) flush = 1'b1;  // Hits the bank enable
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            flush  = 1'b0;
            waited = waited + 1;
        end while (ack);
        check("ack fall cycles", 1, waited);
        if (cancel_at == 2) begin
            flush = 1'b1;  // Hits the collector
            @(posedge clk);
            #1;
            flush = 1'b0;
        end
    endtask

    task automatic do_commit(input logic [2:0] f3, input logic [`LSU_ADDR_W-1:0] addr,
                             input logic [31:0] data, input logic flush_next);
        logic [IDX_W-1:0] idx;
        idx        = addr[`LSU_ADDR_W-1:2];
        ops_issued = ops_issued + 1;
        @(posedge clk);
        #1;
        commit_valid  = 1'b1;
        commit_addr   = addr;
        commit_data   = data;
        commit_funct3 = lsu_pkg::funct3_e'(f3);
        cmt_m[idx]    = ref_merge(cmt_m[idx], data, f3, addr[1:0]);
        @(posedge clk);
        #1;
        commit_valid = 1'b0;
        if (flush_next) begin
            flush = 1'b1;  // Commit still on its way into the bank
            restore_model();
            @(posedge clk);
            #1;
            flush = 1'b0;
        end
    endtask

    task automatic do_flush();
        ops_issued = ops_issued + 1;
        @(posedge clk);
        #1;
        flush = 1'b1;
        restore_model();
        @(posedge clk);
        #1;
        flush = 1'b0;
    endtask

    task automatic probe_lanes(input logic [`LSU_ADDR_W-1:0] word_addr);
        for (int off = 0; off < 4; off++) begin
            do_access(1'b0, 3'b000, word_addr + `LSU_ADDR_W'(off), 32'd0, -1);
            do_access(1'b0, 3'b100, word_addr + `LSU_ADDR_W'(off), 32'd0, -1);
        end
        for (int off = 0; off < 4; off += 2) begin
            do_access(1'b0, 3'b001, word_addr + `LSU_ADDR_W'(off), 32'd0, -1);
            do_access(1'b0, 3'b101, word_addr + `LSU_ADDR_W'(off), 32'd0, -1);
        end
        do_access(1'b0, 3'b010, word_addr, 32'd0, -1);
    endtask

    task automatic run_random(input int count);
        int                     op;
        logic [2:0]             f3;
        logic [`LSU_ADDR_W-1:0] addr;
        logic [31:0]            data;
        for (int n = 0; n < count; n++) begin
            op   = {$random(seed)} % 10;
            addr = `LSU_ADDR_W'($random(seed));
            data = $random(seed);
            if (op < 4) begin
                case ({$random(seed)} % 5)
                    0:       f3 = 3'b000;
                    1:       f3 = 3'b001;
                    2:       f3 = 3'b010;
                    3:       f3 = 3'b100;
                    default: f3 = 3'b101;
                endcase
                do_access(1'b0, f3, align_addr(f3, addr), data, -1);
            end else if (op < 7) begin
                f3 = 3'({$random(seed)} % 3);
                do_access(1'b1, f3, align_addr(f3, addr), data, -1);
            end else if (op < 9) begin
                f3 = 3'({$random(seed)} % 3);
                do_commit(f3, align_addr(f3, addr), data, op == 7);
            end else if (data[0]) begin
                do_flush();
            end else begin
                do_access(data[1], 3'b010, align_addr(3'b010, addr), data, {$random(seed)} % 3);
            end
        end
    endtask

    // Cycle limit grows with every issued operation
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > 40 * ops_issued + 100) begin
            abort_run($sformatf("timeout after %0d cycles with %0d operations issued",
                                cycles, ops_issued));
        end
    end

    always begin
        @(posedge clk);
        #1;
        if (!reset && result_valid) begin
            if (exp_q.size() == 0) begin
                abort_run("result_valid pulsed with no access outstanding");
            end else begin
                exp_r = exp_q.pop_front();
                check("result_data", exp_r[31:0], result_data);
                check("result_addr", exp_r[32 +: `LSU_ADDR_W], result_addr);
                check("result_store", exp_r[32 + `LSU_ADDR_W], result_store);
                check("result_phy", exp_r[33 + `LSU_ADDR_W +: `LSU_PHY_W], result_phy);
                check("result_tag", exp_r[33 + `LSU_ADDR_W + `LSU_PHY_W +: `LSU_TAG_W],
                      result_tag);
            end
        end
    end

    initial begin
        reset         = 1'b1;
        req           = 1'b0;
        req_store     = 1'b0;
        req_funct3    = lsu_pkg::LB;
        req_addr      = '0;
        req_wdata     = '0;
        req_tag       = '0;
        req_phy       = '0;
        commit_valid  = 1'b0;
        commit_addr   = '0;
        commit_data   = '0;
        commit_funct3 = lsu_pkg::LB;
        flush         = 1'b0;
        for (int i = 0; i < NUM_WORDS; i++) begin
            spec_m[i] = 32'(i + 3);
            cmt_m[i]  = 32'(i + 3);
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        check("ack after reset", 0, ack);
        check("result_valid after reset", 0, result_valid);

        test_name = "reset image";
        for (int i = 0; i < NUM_WORDS; i++) begin
            do_access(1'b0, 3'b010, `LSU_ADDR_W'(i * 4), 32'd0, -1);
        end

        test_name = "lane extension";
        for (int b = 0; b < `LSU_NUM_BANKS; b++) begin
            base = `LSU_ADDR_W'(32'h40 + 4 * b);  // One word in every bank
            do_access(1'b1, 3'b010, base, 32'h80ff_7f01, -1);
            probe_lanes(base);
            for (int off = 0; off < 4; off++) begin
                do_access(1'b1, 3'b000, base + `LSU_ADDR_W'(off),
                          32'h017f_80ff >> (8 * off), -1);
            end
            probe_lanes(base);
            do_access(1'b1, 3'b001, base, 32'hdead_8001, -1);
            do_access(1'b1, 3'b001, base + `LSU_ADDR_W'(2), 32'hbeef_7ffe, -1);
            probe_lanes(base);
        end

        test_name = "illegal width";
        do_access(1'b0, 3'b011, `LSU_ADDR_W'(32'h80), 32'd0, -1);
        do_access(1'b0, 3'b110, `LSU_ADDR_W'(32'h80), 32'd0, -1);
        do_access(1'b0, 3'b111, `LSU_ADDR_W'(32'h84), 32'd0, -1);
        do_access(1'b1, 3'b011, `LSU_ADDR_W'(32'h80), 32'h1234_5678, -1);
        do_access(1'b0, 3'b010, `LSU_ADDR_W'(32'h80), 32'd0, -1);

        test_name = "flush restore";
        do_access(1'b1, 3'b010, `LSU_ADDR_W'(32'h100), 32'h1111_2222, -1);
        do_access(1'b1, 3'b010, `LSU_ADDR_W'(32'h104), 32'hcafe_f00d, -1);
        do_commit(3'b010, `LSU_ADDR_W'(32'h104), 32'hcafe_f00d, 1'b0);
        do_commit(3'b000, `LSU_ADDR_W'(32'h109), 32'h0000_00ab, 1'b0);
        do_commit(3'b001, `LSU_ADDR_W'(32'h10a), 32'h0000_8765, 1'b0);
        do_flush();
        for (int i = 0; i < 3; i++) begin
            do_access(1'b0, 3'b010, `LSU_ADDR_W'(32'h100 + 4 * i), 32'd0, -1);
        end
        do_access(1'b0, 3'b000, `LSU_ADDR_W'(32'h109), 32'd0, -1);

        test_name = "commit then flush";
        do_access(1'b1, 3'b010, `LSU_ADDR_W'(32'h10c), 32'h5555_aaaa, -1);
        do_commit(3'b001, `LSU_ADDR_W'(32'h10c), 32'h0000_9abc, 1'b1);
        do_access(1'b0, 3'b010, `LSU_ADDR_W'(32'h10c), 32'd0, -1);

        test_name = "cancelled access";
        for (int c = 0; c < 3; c++) begin
            do_access(1'b1, 3'b010, `LSU_ADDR_W'(32'h110), 32'hffff_0000 | c, c);
        end
        do_access(1'b0, 3'b010, `LSU_ADDR_W'(32'h110), 32'd0, 1);
        do_access(1'b0, 3'b010, `LSU_ADDR_W'(32'h110), 32'd0, -1);

        test_name = "random mix";
        run_random(200);

        while (exp_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);  // Catch any stray report
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== lsu_mem_top.sv ====
`include "lsu_defines.svh"

module lsu_mem_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       req,
    input  logic                       req_store,
    input  lsu_pkg::funct3_e           req_funct3,
    input  logic [`LSU_ADDR_W-1:0]     req_addr,
    input  logic [31:0]                req_wdata,
    input  logic [`LSU_TAG_W-1:0]      req_tag,
    input  logic [`LSU_PHY_W-1:0]      req_phy,
    output logic                       ack,
    input  logic                       commit_valid,
    input  logic [`LSU_ADDR_W-1:0]     commit_addr,
    input  logic [31:0]                commit_data,
    input  lsu_pkg::funct3_e           commit_funct3,
    input  logic                       flush,
    output logic                       result_valid,
    output logic [`LSU_TAG_W-1:0]      result_tag,
    output logic [`LSU_PHY_W-1:0]      result_phy,
    output logic [31:0]                result_data,
    output logic                       result_store,
    output logic [`LSU_ADDR_W-1:0]     result_addr
);

    localparam int WORD_W = $clog2(`LSU_BANK_WORDS);

    logic [`LSU_NUM_BANKS-1:0]                 bank_acc_en;
    logic                                      acc_store;
    lsu_pkg::funct3_e                          acc_funct3;
    logic [WORD_W-1:0]                         acc_word;
    logic [1:0]                                acc_lane_off;
    logic [31:0]                               acc_wdata;
    logic [`LSU_TAG_W-1:0]                     acc_tag;
    logic [`LSU_PHY_W-1:0]                     acc_phy;
    logic [`LSU_NUM_BANKS-1:0]                 bank_cmt_en;
    logic [WORD_W-1:0]                         cmt_word;
    logic [1:0]                                cmt_lane_off;
    logic [31:0]                               cmt_data;
    lsu_pkg::funct3_e                          cmt_funct3;
    logic [`LSU_NUM_BANKS-1:0]                 rsp_valid;
    logic [`LSU_NUM_BANKS-1:0][31:0]           rsp_data;
    logic [`LSU_NUM_BANKS-1:0][`LSU_TAG_W-1:0] rsp_tag;
    logic [`LSU_NUM_BANKS-1:0][`LSU_PHY_W-1:0] rsp_phy;
    logic [`LSU_NUM_BANKS-1:0]                 rsp_store;

    lsu_req_dispatch u_dispatch (
        .clk(clk), .reset(reset),
        .req(req), .req_store(req_store), .req_funct3(req_funct3),
        .req_addr(req_addr), .req_wdata(req_wdata), .req_tag(req_tag), .req_phy(req_phy),
        .commit_valid(commit_valid), .commit_addr(commit_addr),
        .commit_data(commit_data), .commit_funct3(commit_funct3),
        .flush(flush), .ack(ack),
        .bank_acc_en(bank_acc_en), .acc_store(acc_store), .acc_funct3(acc_funct3),
        .acc_word(acc_word), .acc_lane_off(acc_lane_off), .acc_wdata(acc_wdata),
        .acc_tag(acc_tag), .acc_phy(acc_phy),
        .bank_cmt_en(bank_cmt_en), .cmt_word(cmt_word), .cmt_lane_off(cmt_lane_off),
        .cmt_data(cmt_data), .cmt_funct3(cmt_funct3)
    );

    // Shared access and commit buses, one enable bit per bank
    for (genvar g = 0; g < `LSU_NUM_BANKS; g++) begin : g_bank
        mem_bank #(.bank_id(g)) u_bank (
            .clk(clk), .reset(reset), .flush(flush),
            .acc_en(bank_acc_en[g]), .acc_store(acc_store), .acc_funct3(acc_funct3),
            .acc_word(acc_word), .acc_lane_off(acc_lane_off), .acc_wdata(acc_wdata),
            .acc_tag(acc_tag), .acc_phy(acc_phy),
            .cmt_en(bank_cmt_en[g]), .cmt_word(cmt_word), .cmt_lane_off(cmt_lane_off),
            .cmt_data(cmt_data), .cmt_funct3(cmt_funct3),
            .rsp_valid(rsp_valid[g]), .rsp_data(rsp_data[g]), .rsp_tag(rsp_tag[g]),
            .rsp_phy(rsp_phy[g]), .rsp_store(rsp_store[g])
        );
    end

    lsu_result_collect u_collect (
        .clk(clk), .reset(reset), .flush(flush), .acc_word(acc_word),
        .rsp_valid(rsp_valid), .rsp_data(rsp_data), .rsp_tag(rsp_tag),
        .rsp_phy(rsp_phy), .rsp_store(rsp_store),
        .result_valid(result_valid), .result_tag(result_tag), .result_phy(result_phy),
        .result_data(result_data), .result_store(result_store), .result_addr(result_addr)
    );

endmodule

// ==== lsu_result_collect.sv ====
`include "lsu_defines.svh"

module lsu_result_collect (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      flush,
    input  logic [$clog2(`LSU_BANK_WORDS)-1:0]        acc_word,
    input  logic [`LSU_NUM_BANKS-1:0]                 rsp_valid,
    input  logic [`LSU_NUM_BANKS-1:0][31:0]           rsp_data,
    input  logic [`LSU_NUM_BANKS-1:0][`LSU_TAG_W-1:0] rsp_tag,
    input  logic [`LSU_NUM_BANKS-1:0][`LSU_PHY_W-1:0] rsp_phy,
    input  logic [`LSU_NUM_BANKS-1:0]                 rsp_store,
    output logic                                      result_valid,
    output logic [`LSU_TAG_W-1:0]                     result_tag,
    output logic [`LSU_PHY_W-1:0]                     result_phy,
    output logic [31:0]                               result_data,
    output logic                                      result_store,
    output logic [`LSU_ADDR_W-1:0]                    result_addr
);

    localparam int BANK_W = $clog2(`LSU_NUM_BANKS);

    logic [BANK_W-1:0] sel;
    logic              any_rsp;

    // Responding bank is the same one the dispatcher selected
    always_comb begin
        sel = '0;
        for (int b = 0; b < `LSU_NUM_BANKS; b++) begin
            if (rsp_valid[b]) sel = BANK_W'(b);
        end
    end

    assign any_rsp = |rsp_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= any_rsp && !flush;  // Late flush cancels the report
        end
    end

    always_ff @(posedge clk) begin
        if (any_rsp) begin
            result_tag   <= rsp_tag[sel];
            result_phy   <= rsp_phy[sel];
            result_store <= rsp_store[sel];
            result_data  <= rsp_store[sel] ? 32'd0 : rsp_data[sel];
            result_addr  <= {acc_word, sel, 2'b00};  // Word aligned
        end
    end

    // Only one access is ever in flight across the banks
    a_one_rsp: assert property (@(posedge clk) disable iff (reset)
        $onehot0(rsp_valid));

endmodule

// ==== mem_bank.sv ====
`include "lsu_defines.svh"

module mem_bank #(
    parameter int bank_id = 0
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                flush,
    input  logic                                acc_en,
    input  logic                                acc_store,
    input  lsu_pkg::funct3_e                    acc_funct3,
    input  logic [$clog2(`LSU_BANK_WORDS)-1:0]  acc_word,
    input  logic [1:0]                          acc_lane_off,
    input  logic [31:0]                         acc_wdata,
    input  logic [`LSU_TAG_W-1:0]               acc_tag,
    input  logic [`LSU_PHY_W-1:0]               acc_phy,
    input  logic                                cmt_en,
    input  logic [$clog2(`LSU_BANK_WORDS)-1:0]  cmt_word,
    input  logic [1:0]                          cmt_lane_off,
    input  logic [31:0]                         cmt_data,
    input  lsu_pkg::funct3_e                    cmt_funct3,
    output logic                                rsp_valid,
    output logic [31:0]                         rsp_data,
    output logic [`LSU_TAG_W-1:0]               rsp_tag,
    output logic [`LSU_PHY_W-1:0]               rsp_phy,
    output logic                                rsp_store
);

    localparam int WORD_W = $clog2(`LSU_BANK_WORDS);

    lsu_pkg::mem_word_u spec_mem [`LSU_BANK_WORDS];
    lsu_pkg::mem_word_u cmt_mem  [`LSU_BANK_WORDS];

    lsu_pkg::mem_word_u spec_rd;
    lsu_pkg::mem_word_u st_merged;
    lsu_pkg::mem_word_u cmt_merged;
    logic [31:0]        ld_value;

    // Insert the store data into its lane, illegal codes keep the word
    function automatic lsu_pkg::mem_word_u lane_merge(
        input lsu_pkg::mem_word_u old_word,
        input logic [31:0]        data,
        input lsu_pkg::funct3_e   f3,
        input logic [1:0]         off
    );
        lsu_pkg::mem_word_u w;
        w = old_word;
        case (f3)
            lsu_pkg::SB: w.b[off]    = data[7:0];
            lsu_pkg::SH: w.h[off[1]] = data[15:0];
            lsu_pkg::SW: w.h         = data;
            default:     w           = old_word;
        endcase
        return w;
    endfunction

    // Pick the lane and extend from its top bit
    function automatic logic [31:0] load_extract(
        input lsu_pkg::mem_word_u w,
        input lsu_pkg::funct3_e   f3,
        input logic [1:0]         off
    );
        logic [7:0]  byte_v;
        logic [15:0] half_v;
        byte_v = w.b[off];
        half_v = w.h[off[1]];
        case (f3)
            lsu_pkg::LB:  return {{24{byte_v[7]}}, byte_v};
            lsu_pkg::LH:  return {{16{half_v[15]}}, half_v};
            lsu_pkg::LW:  return w.h;
            lsu_pkg::LBU: return {24'd0, byte_v};
            lsu_pkg::LHU: return {16'd0, half_v};
            default:      return 32'd0;  // Illegal width reads zero
        endcase
    endfunction

    assign spec_rd    = spec_mem[acc_word];
    assign st_merged  = lane_merge(spec_rd, acc_wdata, acc_funct3, acc_lane_off);
    assign cmt_merged = lane_merge(cmt_mem[cmt_word], cmt_data, cmt_funct3, cmt_lane_off);
    assign ld_value   = load_extract(spec_rd, acc_funct3, acc_lane_off);

    always_ff @(posedge clk) begin
        if (reset) begin
            // Global word index is word-in-bank times banks plus bank
            for (int i = 0; i < `LSU_BANK_WORDS; i++) begin
                spec_mem[i] <= 32'(i * `LSU_NUM_BANKS + bank_id + 3);
                cmt_mem[i]  <= 32'(i * `LSU_NUM_BANKS + bank_id + 3);
            end
        end else begin
            if (flush) begin
                // A commit landing this edge is already part of the image
                for (int i = 0; i < `LSU_BANK_WORDS; i++) begin
                    if (cmt_en && cmt_word == WORD_W'(i)) begin
                        spec_mem[i] <= cmt_merged;
                    end else begin
                        spec_mem[i] <= cmt_mem[i];
                    end
                end
            end else if (acc_en && acc_store) begin
                spec_mem[acc_word] <= st_merged;
            end
            if (cmt_en) cmt_mem[cmt_word] <= cmt_merged;  // Retired store
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= acc_en;
        end
    end

    always_ff @(posedge clk) begin
        if (acc_en) begin
            rsp_data  <= ld_value;
            rsp_tag   <= acc_tag;
            rsp_phy   <= acc_phy;
            rsp_store <= acc_store;
        end
    end

    // Dispatcher gates the access off during a flush
    a_acc_flush: assert property (@(posedge clk) disable iff (reset)
        !(acc_en && flush));

endmodule

// ==== lsu_req_dispatch.sv ====
`include "lsu_defines.svh"

module lsu_req_dispatch (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    req,
    input  logic                                    req_store,
    input  lsu_pkg::funct3_e                        req_funct3,
    input  logic [`LSU_ADDR_W-1:0]                  req_addr,
    input  logic [31:0]                             req_wdata,
    input  logic [`LSU_TAG_W-1:0]                   req_tag,
    input  logic [`LSU_PHY_W-1:0]                   req_phy,
    input  logic                                    commit_valid,
    input  logic [`LSU_ADDR_W-1:0]                  commit_addr,
    input  logic [31:0]                             commit_data,
    input  lsu_pkg::funct3_e                        commit_funct3,
    input  logic                                    flush,
    output logic                                    ack,
    output logic [`LSU_NUM_BANKS-1:0]               bank_acc_en,
    output logic                                    acc_store,
    output lsu_pkg::funct3_e                        acc_funct3,
    output logic [$clog2(`LSU_BANK_WORDS)-1:0]      acc_word,
    output logic [1:0]                              acc_lane_off,
    output logic [31:0]                             acc_wdata,
    output logic [`LSU_TAG_W-1:0]                   acc_tag,
    output logic [`LSU_PHY_W-1:0]                   acc_phy,
    output logic [`LSU_NUM_BANKS-1:0]               bank_cmt_en,
    output logic [$clog2(`LSU_BANK_WORDS)-1:0]      cmt_word,
    output logic [1:0]                              cmt_lane_off,
    output logic [31:0]                             cmt_data,
    output lsu_pkg::funct3_e                        cmt_funct3
);

    localparam int BANK_W = $clog2(`LSU_NUM_BANKS);
    localparam int WORD_W = $clog2(`LSU_BANK_WORDS);
    localparam logic S_IDLE  = 1'b0;
    localparam logic S_ACKED = 1'b1;

    logic                     state;
    logic                     accept;
    logic [BANK_W-1:0]        req_bank;
    logic [BANK_W-1:0]        cmt_bank;
    logic [`LSU_NUM_BANKS-1:0] acc_en_q;

    // Byte address is word-in-bank, bank, lane
    assign req_bank = req_addr[2 +: BANK_W];
    assign cmt_bank = commit_addr[2 +: BANK_W];
    assign accept   = (state == S_IDLE) && req;
    assign ack      = (state == S_ACKED);

    // Flush drops the access that would hit the banks this cycle
    assign bank_acc_en = acc_en_q & ~{`LSU_NUM_BANKS{flush}};

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= S_IDLE;
            acc_en_q <= '0;
        end else begin
            acc_en_q <= '0;
            case (state)
                S_IDLE: if (req) begin
                    state    <= S_ACKED;
                    acc_en_q <= flush ? '0 : (`LSU_NUM_BANKS'(1) << req_bank);
                end
                S_ACKED: if (!req) state <= S_IDLE;  // Requester released
                default: state <= S_IDLE;
            endcase
        end
    end

    // Access payload, stable until the next accepted request
    always_ff @(posedge clk) begin
        if (accept) begin
            acc_store    <= req_store;
            acc_funct3   <= req_funct3;
            acc_word     <= req_addr[2 + BANK_W +: WORD_W];
            acc_lane_off <= req_addr[1:0];
            acc_wdata    <= req_wdata;
            acc_tag      <= req_tag;
            acc_phy      <= req_phy;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bank_cmt_en <= '0;
        end else begin
            bank_cmt_en <= commit_valid ? (`LSU_NUM_BANKS'(1) << cmt_bank) : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (commit_valid) begin
            cmt_word     <= commit_addr[2 + BANK_W +: WORD_W];
            cmt_lane_off <= commit_addr[1:0];
            cmt_data     <= commit_data;
            cmt_funct3   <= commit_funct3;
        end
    end

    a_half_aligned: assert property (@(posedge clk) disable iff (reset)
        (req && !ack && req_funct3[1:0] == 2'b01) |-> !req_addr[0]);

    a_word_aligned: assert property (@(posedge clk) disable iff (reset)
        (req && !ack && req_funct3[1:0] == 2'b10) |-> req_addr[1:0] == 2'b00);

    // Requester may only release after seeing ack
    a_req_held: assert property (@(posedge clk) disable iff (reset)
        $fell(req) |-> ack);

    a_cmt_flush: assert property (@(posedge clk) disable iff (reset)
        !(commit_valid && flush));

endmodule

// ==== lsu_pkg.sv ====
package lsu_pkg;

    // RISC-V funct3 access width codes for loads
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } funct3_e;

    // Stores reuse the load codes of the same width
    localparam funct3_e SB = LB;
    localparam funct3_e SH = LH;
    localparam funct3_e SW = LW;

    // One memory word, seen as bytes or as halfwords
    typedef union packed {
        logic [3:0][7:0]  b;  // Byte lanes, b[0] is the lowest address
        logic [1:0][15:0] h;  // Halfword lanes
    } mem_word_u;

endpackage

// ==== lsu_defines.svh ====
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Interleaved banks, power of two only
`define LSU_NUM_BANKS 4

// 32-bit words held by each bank
`define LSU_BANK_WORDS 64

// Byte address width, covers banks times words times four bytes
`define LSU_ADDR_W 10

// Instruction tag carried from issue to the result bus
`define LSU_TAG_W 8

// Physical destination register index
`define LSU_PHY_W 8

`endif
